// File: design/aluart_consts.svh
`ifndef ALUART_CONSTS_SVH
`define ALUART_CONSTS_SVH

////////////////////////////////////////////////////////////////////////////
// Serial line framing.
////////////////////////////////////////////////////////////////////////////

// Data bits per UART byte, also the ALU operand width.
`define ALUART_DATA_BITS 8

// Clock cycles per serial bit.
`define ALUART_CLOCKS_PER_BIT 16

// Stop bits per frame.
`define ALUART_STOP_BITS 1

`endif

// File: design/uart_pkg.sv
`default_nettype none

`include "aluart_consts.svh"

package uart_pkg;

    // One byte as carried on the serial line.
    typedef struct packed {
        logic [`ALUART_DATA_BITS-1:0] data;
    } uart_byte_t;

    // Receiver states.
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Transmitter states.
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

`default_nettype wire

// File: design/alu_pkg.sv
`default_nettype none

`include "aluart_consts.svh"

package alu_pkg;

    // Opcodes as sent by the host.
    typedef enum logic [7:0] {
        ALU_OP_SRL = 8'h02,
        ALU_OP_SRA = 8'h03,
        ALU_OP_ADD = 8'h20,
        ALU_OP_SUB = 8'h22,
        ALU_OP_AND = 8'h24,
        ALU_OP_OR  = 8'h25,
        ALU_OP_XOR = 8'h26,
        ALU_OP_NOR = 8'h27
    } alu_op_e;

    // One request, in the order the bytes arrive.
    typedef struct packed {
        logic [`ALUART_DATA_BITS-1:0] a;
        alu_op_e                      op;
        logic [`ALUART_DATA_BITS-1:0] b;
    } alu_request_t;

    typedef struct packed {
        logic [`ALUART_DATA_BITS-1:0] value;
    } alu_result_t;

    // Frame controller states.
    typedef enum logic [2:0] {
        FRAME_WAIT_A,
        FRAME_WAIT_OP,
        FRAME_WAIT_B,
        FRAME_COMPUTE,
        FRAME_SEND,
        FRAME_SENDING
    } frame_state_e;

endpackage

`default_nettype wire

// File: design/uart_rx.sv
`default_nettype none
`timescale 1ns/100ps

`include "aluart_consts.svh"

module uart_rx (
    input  wire logic           i_clock,
    input  wire logic           i_reset,
    input  wire logic           i_rx,
    output uart_pkg::uart_byte_t o_byte,
    output logic                o_valid
);

    localparam int unsigned CPB     = `ALUART_CLOCKS_PER_BIT;
    localparam int unsigned DB      = `ALUART_DATA_BITS;
    localparam int unsigned COUNT_W = $clog2(CPB);
    localparam int unsigned BIT_W   = $clog2(DB);

    localparam logic [COUNT_W-1:0] HALF_LAST = COUNT_W'(CPB / 2 - 1);
    localparam logic [COUNT_W-1:0] BIT_LAST  = COUNT_W'(CPB - 1);
    localparam logic [BIT_W-1:0]   DATA_LAST = BIT_W'(DB - 1);

    logic [1:0]          sync_q;
    logic                rx_bit;
    uart_pkg::rx_state_e state_q;
    logic [COUNT_W-1:0]  count_q;
    logic [BIT_W-1:0]    bit_q;
    logic [DB-1:0]       shift_q;

    ////////////////////////////////////////////////////////////////////////////
    // Input synchronizer.
    ////////////////////////////////////////////////////////////////////////////

    // Idle line is high.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], i_rx};
        end
    end

    assign rx_bit = sync_q[1];

    ////////////////////////////////////////////////////////////////////////////
    // Bit timing and framing.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q <= uart_pkg::RX_IDLE;
            count_q <= '0;
            bit_q   <= '0;
            o_valid <= 1'b0;
        end else begin
            o_valid <= 1'b0;
            case (state_q)
                uart_pkg::RX_IDLE: begin
                    count_q <= '0;
                    if (!rx_bit) begin
                        state_q <= uart_pkg::RX_START;
                    end
                end
                uart_pkg::RX_START: begin
                    // Recheck the line at half a bit; a short glitch is dropped.
                    if (count_q == HALF_LAST) begin
                        count_q <= '0;
                        bit_q   <= '0;
                        state_q <= rx_bit ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (count_q == BIT_LAST) begin
                        count_q <= '0;
                        if (bit_q == DATA_LAST) begin
                            state_q <= uart_pkg::RX_STOP;
                        end else begin
                            bit_q <= bit_q + 1'b1;
                        end
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                uart_pkg::RX_STOP: begin
                    if (count_q == BIT_LAST) begin
                        // Byte is only passed on with a good stop bit.
                        o_valid <= rx_bit;
                        state_q <= uart_pkg::RX_IDLE;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= uart_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data arrives LSB first.
    always_ff @(posedge i_clock) begin
        if (state_q == uart_pkg::RX_DATA && count_q == BIT_LAST) begin
            shift_q <= {rx_bit, shift_q[DB-1:1]};
        end
    end

    assign o_byte.data = shift_q;

endmodule

`default_nettype wire

// File: design/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps

`include "aluart_consts.svh"

module uart_tx (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire uart_pkg::uart_byte_t i_byte,
    input  wire logic                 i_valid,
    output logic                      o_ready,
    output logic                      o_tx
);

    localparam int unsigned CPB     = `ALUART_CLOCKS_PER_BIT;
    localparam int unsigned DB      = `ALUART_DATA_BITS;
    localparam int unsigned COUNT_W = $clog2(CPB * `ALUART_STOP_BITS);
    localparam int unsigned BIT_W   = $clog2(DB);

    localparam logic [COUNT_W-1:0] BIT_LAST  = COUNT_W'(CPB - 1);
    localparam logic [COUNT_W-1:0] STOP_LAST = COUNT_W'(CPB * `ALUART_STOP_BITS - 1);
    localparam logic [BIT_W-1:0]   DATA_LAST = BIT_W'(DB - 1);

    uart_pkg::tx_state_e state_q;
    logic [COUNT_W-1:0]  count_q;
    logic [BIT_W-1:0]    bit_q;
    logic [DB-1:0]       shift_q;
    logic                tx_q;
    logic                accept;

    assign o_ready = (state_q == uart_pkg::TX_IDLE);
    assign accept  = o_ready && i_valid;
    assign o_tx    = tx_q;

    // Line level is registered, so the start bit begins the cycle after accept.
    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q <= uart_pkg::TX_IDLE;
            count_q <= '0;
            bit_q   <= '0;
            tx_q    <= 1'b1;
        end else begin
            case (state_q)
                uart_pkg::TX_IDLE: begin
                    count_q <= '0;
                    bit_q   <= '0;
                    if (accept) begin
                        tx_q    <= 1'b0;
                        state_q <= uart_pkg::TX_START;
                    end
                end
                uart_pkg::TX_START: begin
                    if (count_q == BIT_LAST) begin
                        count_q <= '0;
                        tx_q    <= shift_q[0];
                        state_q <= uart_pkg::TX_DATA;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (count_q == BIT_LAST) begin
                        count_q <= '0;
                        if (bit_q == DATA_LAST) begin
                            tx_q    <= 1'b1;
                            state_q <= uart_pkg::TX_STOP;
                        end else begin
                            // Next bit is already in position 1 before the shift.
                            tx_q  <= shift_q[1];
                            bit_q <= bit_q + 1'b1;
                        end
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                uart_pkg::TX_STOP: begin
                    if (count_q == STOP_LAST) begin
                        state_q <= uart_pkg::TX_IDLE;
                    end else begin
                        count_q <= count_q + 1'b1;
                    end
                end
                default: begin
                    state_q <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            shift_q <= i_byte.data;
        end else if (state_q == uart_pkg::TX_DATA && count_q == BIT_LAST) begin
            shift_q <= {1'b0, shift_q[DB-1:1]};
        end
    end

endmodule

`default_nettype wire

// File: design/alu.sv
`default_nettype none
`timescale 1ns/100ps

module alu (
    input  wire logic                  i_clock,
    input  wire logic                  i_reset,
    input  wire alu_pkg::alu_request_t i_req,
    input  wire logic                  i_req_valid,
    output logic                       o_req_ready,
    output alu_pkg::alu_result_t       o_res,
    output logic                       o_res_valid,
    input  wire logic                  i_res_ready
);

    alu_pkg::alu_result_t result;
    alu_pkg::alu_result_t res_q;
    logic                 res_valid_q;
    logic                 accept;

    ////////////////////////////////////////////////////////////////////////////
    // Operation select.
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_req.op)
            alu_pkg::ALU_OP_ADD: result.value = i_req.a + i_req.b;
            alu_pkg::ALU_OP_SUB: result.value = i_req.a - i_req.b;
            alu_pkg::ALU_OP_AND: result.value = i_req.a & i_req.b;
            alu_pkg::ALU_OP_OR:  result.value = i_req.a | i_req.b;
            alu_pkg::ALU_OP_XOR: result.value = i_req.a ^ i_req.b;
            alu_pkg::ALU_OP_NOR: result.value = ~(i_req.a | i_req.b);
            // Shift amount is the low three bits of B.
            alu_pkg::ALU_OP_SRL: result.value = i_req.a >> i_req.b[2:0];
            alu_pkg::ALU_OP_SRA: result.value = $signed(i_req.a) >>> i_req.b[2:0];
            default:             result.value = '0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // One-entry output stage.
    ////////////////////////////////////////////////////////////////////////////

    // Free when empty or draining this cycle.
    assign o_req_ready = !res_valid_q || i_res_ready;
    assign accept      = i_req_valid && o_req_ready;

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            res_valid_q <= 1'b0;
        end else if (accept) begin
            res_valid_q <= 1'b1;
        end else if (i_res_ready) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge i_clock) begin
        if (accept) begin
            res_q <= result;
        end
    end

    assign o_res       = res_q;
    assign o_res_valid = res_valid_q;

endmodule

`default_nettype wire

// File: design/alu_frame_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module alu_frame_ctrl (
    input  wire logic                 i_clock,
    input  wire logic                 i_reset,
    input  wire uart_pkg::uart_byte_t i_rx_byte,
    input  wire logic                 i_rx_valid,
    output alu_pkg::alu_request_t     o_alu_req,
    output logic                      o_alu_req_valid,
    input  wire logic                 i_alu_req_ready,
    input  wire alu_pkg::alu_result_t i_alu_res,
    input  wire logic                 i_alu_res_valid,
    output logic                      o_alu_res_ready,
    output uart_pkg::uart_byte_t      o_tx_byte,
    output logic                      o_tx_valid,
    input  wire logic                 i_tx_ready
);

    alu_pkg::frame_state_e state_q;
    alu_pkg::alu_request_t req_q;
    alu_pkg::alu_result_t  res_q;
    logic                  req_sent_q;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake outputs, decoded from the state.
    ////////////////////////////////////////////////////////////////////////////

    assign o_alu_req_valid = (state_q == alu_pkg::FRAME_COMPUTE) && !req_sent_q;
    assign o_alu_res_ready = (state_q == alu_pkg::FRAME_COMPUTE);
    assign o_tx_valid      = (state_q == alu_pkg::FRAME_SEND);

    assign o_alu_req      = req_q;
    assign o_tx_byte.data = res_q.value;

    ////////////////////////////////////////////////////////////////////////////
    // Frame sequencing.
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_clock) begin
        if (!i_reset) begin
            state_q    <= alu_pkg::FRAME_WAIT_A;
            req_sent_q <= 1'b0;
        end else begin
            case (state_q)
                alu_pkg::FRAME_WAIT_A: begin
                    if (i_rx_valid) begin
                        state_q <= alu_pkg::FRAME_WAIT_OP;
                    end
                end
                alu_pkg::FRAME_WAIT_OP: begin
                    if (i_rx_valid) begin
                        state_q <= alu_pkg::FRAME_WAIT_B;
                    end
                end
                alu_pkg::FRAME_WAIT_B: begin
                    if (i_rx_valid) begin
                        req_sent_q <= 1'b0;
                        state_q    <= alu_pkg::FRAME_COMPUTE;
                    end
                end
                alu_pkg::FRAME_COMPUTE: begin
                    // Request goes out once, then wait for the result.
                    if (o_alu_req_valid && i_alu_req_ready) begin
                        req_sent_q <= 1'b1;
                    end
                    if (i_alu_res_valid) begin
                        state_q <= alu_pkg::FRAME_SEND;
                    end
                end
                alu_pkg::FRAME_SEND: begin
                    if (i_tx_ready) begin
                        state_q <= alu_pkg::FRAME_SENDING;
                    end
                end
                alu_pkg::FRAME_SENDING: begin
                    // Ready comes back high only at the end of the stop bit.
                    if (i_tx_ready) begin
                        state_q <= alu_pkg::FRAME_WAIT_A;
                    end
                end
                default: begin
                    state_q <= alu_pkg::FRAME_WAIT_A;
                end
            endcase
        end
    end

    // Operand and result capture.
    always_ff @(posedge i_clock) begin
        if (i_rx_valid && state_q == alu_pkg::FRAME_WAIT_A) begin
            req_q.a <= i_rx_byte.data;
        end
        if (i_rx_valid && state_q == alu_pkg::FRAME_WAIT_OP) begin
            req_q.op <= alu_pkg::alu_op_e'(i_rx_byte.data);
        end
        if (i_rx_valid && state_q == alu_pkg::FRAME_WAIT_B) begin
            req_q.b <= i_rx_byte.data;
        end
        if (i_alu_res_valid && o_alu_res_ready) begin
            res_q <= i_alu_res;
        end
    end

endmodule

`default_nettype wire

// File: design/aluart_top.sv
`default_nettype none
`timescale 1ns/100ps

module aluart_top (
    input  wire logic i_clock,
    input  wire logic i_reset,
    input  wire logic i_rx,
    output logic      o_tx
);

    uart_pkg::uart_byte_t  rx_byte;
    logic                  rx_valid;
    alu_pkg::alu_request_t alu_req;
    logic                  alu_req_valid;
    logic                  alu_req_ready;
    alu_pkg::alu_result_t  alu_res;
    logic                  alu_res_valid;
    logic                  alu_res_ready;
    uart_pkg::uart_byte_t  tx_byte;
    logic                  tx_valid;
    logic                  tx_ready;

    uart_rx uart_rx_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_byte  (rx_byte),
        .o_valid (rx_valid)
    );

    alu_frame_ctrl alu_frame_ctrl_i (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_rx_byte       (rx_byte),
        .i_rx_valid      (rx_valid),
        .o_alu_req       (alu_req),
        .o_alu_req_valid (alu_req_valid),
        .i_alu_req_ready (alu_req_ready),
        .i_alu_res       (alu_res),
        .i_alu_res_valid (alu_res_valid),
        .o_alu_res_ready (alu_res_ready),
        .o_tx_byte       (tx_byte),
        .o_tx_valid      (tx_valid),
        .i_tx_ready      (tx_ready)
    );

    alu alu_i (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_req       (alu_req),
        .i_req_valid (alu_req_valid),
        .o_req_ready (alu_req_ready),
        .o_res       (alu_res),
        .o_res_valid (alu_res_valid),
        .i_res_ready (alu_res_ready)
    );

    uart_tx uart_tx_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_byte  (tx_byte),
        .i_valid (tx_valid),
        .o_ready (tx_ready),
        .o_tx    (o_tx)
    );

endmodule

`default_nettype wire

// File: verification/aluart_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "aluart_consts.svh"

module aluart_tb;

    localparam int CPB            = `ALUART_CLOCKS_PER_BIT;
    localparam int OPCODE_COUNT   = 8;
    localparam int RANDOM_FRAMES  = 200;
    localparam int UNKNOWN_FRAMES = 16;
    // Sent and reply bytes over all tests, idle gaps counted as bytes.
    localparam int TOTAL_BYTES    = 2 + 4 * (OPCODE_COUNT + RANDOM_FRAMES + UNKNOWN_FRAMES) + 17;
    localparam int CYCLE_LIMIT    = TOTAL_BYTES * 10 * CPB * 2;
    localparam int REPLY_WAIT     = 2 * 10 * CPB;

    logic       i_clock = 1'b0;
    logic       i_reset;
    logic       i_rx;
    logic       o_tx;
    logic [7:0] reply_q[$];
    logic [31:0] rng_state = 32'h8dcf;
    int         cycle_count = 0;
    int         pass_count = 0;
    int         fail_count = 0;
    int         test_errors = 0;

    aluart_top aluart_top_i (
        .i_clock (i_clock),
        .i_reset (i_reset),
        .i_rx    (i_rx),
        .o_tx    (o_tx)
    );

    always #50 i_clock = ~i_clock;

    always @(posedge i_clock) begin
        cycle_count <= cycle_count + 1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random numbers and the ALU model.
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [7:0] random_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[7:0];
    endfunction

    function automatic logic [7:0] opcode_at(input int idx);
        case (idx)
            0: return 8'h20;
            1: return 8'h22;
            2: return 8'h24;
            3: return 8'h25;
            4: return 8'h26;
            5: return 8'h27;
            6: return 8'h02;
            default: return 8'h03;
        endcase
    endfunction

    function automatic logic is_known_op(input logic [7:0] op);
        case (op)
            8'h02, 8'h03, 8'h20, 8'h22, 8'h24, 8'h25, 8'h26, 8'h27: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [7:0] expected_result(input logic [7:0] a,
                                                   input logic [7:0] op,
                                                   input logic [7:0] b);
        logic [15:0] shifted;
        // Sign extended A, shifted as a wide word for the arithmetic case.
        shifted = {{8{a[7]}}, a} >> b[2:0];
        case (op)
            8'h20: return a + b;
            8'h22: return a - b;
            8'h24: return a & b;
            8'h25: return a | b;
            8'h26: return a ^ b;
            8'h27: return ~(a | b);
            8'h02: return a >> b[2:0];
            8'h03: return shifted[7:0];
            default: return 8'h00;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Serial driver and bookkeeping.
    ////////////////////////////////////////////////////////////////////////////

    // Start bit, data LSB first, then the stop bit.
    task automatic send_byte(input logic [7:0] value, input logic bad_stop);
        logic [`ALUART_DATA_BITS+1:0] frame;
        int i;
        frame = {~bad_stop, value, 1'b0};
        for (i = 0; i < `ALUART_DATA_BITS + 2; i++) begin
            i_rx <= frame[i];
            repeat (CPB) @(posedge i_clock);
        end
    endtask

    task automatic drive_idle(input int bits);
        i_rx <= 1'b1;
        repeat (bits * CPB) @(posedge i_clock);
    endtask

    task automatic send_frame(input logic [7:0] a, input logic [7:0] op, input logic [7:0] b);
        send_byte(a, 1'b0);
        send_byte(op, 1'b0);
        send_byte(b, 1'b0);
    endtask

    task automatic count_fail();
        fail_count  = fail_count + 1;
        test_errors = test_errors + 1;
    endtask

    task automatic check_reply(input logic [7:0] expected);
        logic [7:0] actual;
        int waited;
        waited = 0;
        while (reply_q.size() == 0 && waited < REPLY_WAIT) begin
            @(posedge i_clock);
            waited = waited + 1;
        end
        if (reply_q.size() == 0) begin
            $display("no reply byte on o_tx within %0d cycles, at %0t", REPLY_WAIT, $time);
            count_fail();
        end else begin
            actual = reply_q.pop_front();
            if (actual !== expected) begin
                $display("mismatch at %0t: o_tx expected 8'h%02h got 8'h%02h",
                         $time, expected, actual);
                count_fail();
            end else begin
                pass_count = pass_count + 1;
            end
        end
    endtask

    task automatic run_frame(input logic [7:0] a, input logic [7:0] op, input logic [7:0] b);
        send_frame(a, op, b);
        check_reply(expected_result(a, op, b));
        drive_idle(1);
    endtask

    task automatic finish_test(input string name);
        $display("test %s finished with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Reply monitor, samples o_tx at mid-bit.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : reply_monitor
        logic [7:0] data;
        int i;
        forever begin
            @(posedge i_clock);
            if (i_reset === 1'b1 && o_tx === 1'b0) begin
                repeat (CPB / 2) @(posedge i_clock);
                if (o_tx !== 1'b0) begin
                    $display("start bit on o_tx lasted under half a bit, at %0t", $time);
                    count_fail();
                end else begin
                    for (i = 0; i < 8; i++) begin
                        repeat (CPB) @(posedge i_clock);
                        data[i] = o_tx;
                    end
                    repeat (CPB) @(posedge i_clock);
                    if (o_tx !== 1'b1) begin
                        $display("reply on o_tx ended with a low stop bit, at %0t", $time);
                        count_fail();
                    end else begin
                        reply_q.push_back(data);
                    end
                end
            end
        end
    end

    initial begin : run_limit
        wait (cycle_count >= CYCLE_LIMIT);
        $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
        $display("SIMULATION FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence.
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main_sequence
        logic [7:0] a;
        logic [7:0] op;
        logic [7:0] b;
        logic       low_seen;
        int         n;
        i_reset = 1'b0;
        i_rx    = 1'b1;
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b1;

        // Line must stay idle with no input.
        low_seen = 1'b0;
        for (n = 0; n < 20 * CPB; n++) begin
            @(posedge i_clock);
            if (o_tx !== 1'b1 && !low_seen) begin
                $display("mismatch at %0t: o_tx expected 1'b1 got 1'b%b", $time, o_tx);
                low_seen = 1'b1;
            end
        end
        if (low_seen) begin
            count_fail();
        end else begin
            pass_count = pass_count + 1;
        end
        finish_test("reset state");

        for (n = 0; n < OPCODE_COUNT; n++) begin
            a = random_byte();
            b = random_byte();
            run_frame(a, opcode_at(n), b);
        end
        finish_test("each opcode");

        for (n = 0; n < RANDOM_FRAMES; n++) begin
            a  = random_byte();
            op = opcode_at(random_byte() % 8);
            b  = random_byte();
            run_frame(a, op, b);
        end
        finish_test("random frames");

        for (n = 0; n < UNKNOWN_FRAMES; n++) begin
            a  = random_byte();
            op = random_byte();
            while (is_known_op(op)) begin
                op = random_byte();
            end
            b = random_byte();
            send_frame(a, op, b);
            check_reply(8'h00);
            drive_idle(1);
        end
        finish_test("unknown opcodes");

        // Bad stop bit, then a clean frame.
        send_byte(random_byte(), 1'b1);
        drive_idle(2);
        a  = random_byte();
        op = opcode_at(random_byte() % 8);
        b  = random_byte();
        run_frame(a, op, b);
        finish_test("framing error");

        // Extra byte lands while the reply is still on the line.
        a  = random_byte();
        op = opcode_at(random_byte() % 8);
        b  = random_byte();
        send_frame(a, op, b);
        send_byte(random_byte(), 1'b0);
        check_reply(expected_result(a, op, b));
        drive_idle(1);
        a  = random_byte();
        op = opcode_at(random_byte() % 8);
        b  = random_byte();
        run_frame(a, op, b);
        drive_idle(12);
        if (reply_q.size() != 0) begin
            $display("an extra reply byte appeared on o_tx, at %0t", $time);
            count_fail();
        end else begin
            pass_count = pass_count + 1;
        end
        finish_test("bytes during reply");

        $display("checks passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: aluart.f
+incdir+design
design/uart_pkg.sv
design/alu_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/alu.sv
design/alu_frame_ctrl.sv
design/aluart_top.sv
verification/aluart_tb.sv

// File: Bender.yml
package:
  name: aluart

sources:
  - include_dirs:
      - design
    files:
      - design/uart_pkg.sv
      - design/alu_pkg.sv
      - design/uart_rx.sv
      - design/uart_tx.sv
      - design/alu.sv
      - design/alu_frame_ctrl.sv
      - design/aluart_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - verification/aluart_tb.sv
